// ==== common/lsu_pkg.sv ====
package lsu_pkg;

   // ====================
   // datapath widths
   // ====================

   // one ram word per address
   parameter int DATA_W = 32;
   // byte lanes per word
   parameter int BE_W   = DATA_W / 8;
   // load tag, handed back with the load result
   parameter int TAG_W  = 4;

   // ====================
   // init control
   // ====================

   // clear sweep first, then normal issue
   typedef enum logic [0:0] {
      ST_CLEAR = 1'b0,
      ST_RUN   = 1'b1
   } lsu_state_e;

   // ====================
   // pipeline opcodes
   // ====================

   // op carried from ex0 into ex1
   // OP_NONE is a bubble
   typedef enum logic [1:0] {
      OP_NONE  = 2'b00,
      OP_LOAD  = 2'b01,
      OP_STORE = 2'b10
   } lsu_op_e;

endpackage : lsu_pkg

// ==== source/lsu_init_fsm.sv ====
`timescale 1ns/100ps

module lsu_init_fsm (
   input  logic i_clk,
   input  logic i_rst,
   // counter sits on the top word
   input  logic i_last,
   output logic o_clear_en,
   output logic o_run
);

   import lsu_pkg::*;

   lsu_state_e r_state;
   lsu_state_e w_state_nxt;

   // ====================
   // next state
   // ====================

   always_comb begin
      w_state_nxt = r_state;
      case (r_state)
         // leave once the top word gets its write
         ST_CLEAR: begin
            if (i_last) begin
               w_state_nxt = ST_RUN;
            end
         end
         // no way back short of reset
         ST_RUN: begin
            w_state_nxt = ST_RUN;
         end
         default: begin
            w_state_nxt = ST_CLEAR;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_state <= ST_CLEAR;
      end else begin
         r_state <= w_state_nxt;
      end
   end

   // decoded straight from the state reg
   assign o_clear_en = (r_state == ST_CLEAR);
   assign o_run      = (r_state == ST_RUN);

endmodule : lsu_init_fsm

// ==== source/lsu_init_ctr.sv ====
`timescale 1ns/100ps

module lsu_init_ctr #(
   parameter int ADDR_W = 6
) (
   input  logic              i_clk,
   input  logic              i_rst,
   // step while the sweep runs
   input  logic              i_en,
   output logic [ADDR_W-1:0] o_addr,
   output logic              o_last
);

   logic [ADDR_W-1:0] r_addr;

   // wraps back to zero after the top word
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_addr <= '0;
      end else if (i_en) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   assign o_addr = r_addr;
   // all ones marks the final word
   assign o_last = &r_addr;

endmodule : lsu_init_ctr

// ==== replay/lsu_replay_buf.sv ====
`timescale 1ns/100ps

module lsu_replay_buf #(
   parameter int ADDR_W      = 6,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                       i_clk,
   input  logic                       i_rst,

   // sender spends one credit per push
   input  logic                       i_push,
   input  logic [ADDR_W-1:0]          i_push_addr,
   input  logic [lsu_pkg::DATA_W-1:0] i_push_data,
   input  logic [lsu_pkg::BE_W-1:0]   i_push_be,
   input  logic [lsu_pkg::TAG_W-1:0]  i_push_tag,

   // each pop frees one entry
   input  logic                       i_pop,
   output logic                       o_head_valid,
   output logic [ADDR_W-1:0]          o_head_addr,
   output logic [lsu_pkg::DATA_W-1:0] o_head_data,
   output logic [lsu_pkg::BE_W-1:0]   o_head_be,
   output logic [lsu_pkg::TAG_W-1:0]  o_head_tag
);

   import lsu_pkg::*;

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   // entry storage
   logic [ADDR_W-1:0] r_addr [QUEUE_DEPTH];
   logic [DATA_W-1:0] r_data [QUEUE_DEPTH];
   logic [BE_W-1:0]   r_be   [QUEUE_DEPTH];
   logic [TAG_W-1:0]  r_tag  [QUEUE_DEPTH];

   logic [PTR_W-1:0]  r_wr_ptr;
   logic [PTR_W-1:0]  r_rd_ptr;
   logic [CNT_W-1:0]  r_count;

   // ====================
   // pointers and count
   // ====================

   // the sender is out of credits whenever the buffer is full
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end else begin
         if (i_push) begin
            if (r_wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
               r_wr_ptr <= '0;
            end else begin
               r_wr_ptr <= r_wr_ptr + 1'b1;
            end
         end
         if (i_pop) begin
            if (r_rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
               r_rd_ptr <= '0;
            end else begin
               r_rd_ptr <= r_rd_ptr + 1'b1;
            end
         end
         case ({i_push, i_pop})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;
         endcase
      end
   end

   // payload lands in the write slot
   always_ff @(posedge i_clk) begin
      if (i_push) begin
         r_addr[r_wr_ptr] <= i_push_addr;
         r_data[r_wr_ptr] <= i_push_data;
         r_be[r_wr_ptr]   <= i_push_be;
         r_tag[r_wr_ptr]  <= i_push_tag;
      end
   end

   // head visible the cycle after its push
   assign o_head_valid = (r_count != '0);
   assign o_head_addr  = r_addr[r_rd_ptr];
   assign o_head_data  = r_data[r_rd_ptr];
   assign o_head_be    = r_be[r_rd_ptr];
   assign o_head_tag   = r_tag[r_rd_ptr];

endmodule : lsu_replay_buf

// ==== replay/lsu_replay_arb.sv ====
`timescale 1ns/100ps

module lsu_replay_arb #(
   parameter int ADDR_W = 6
) (
   // picks held off until the clear sweep ends
   input  logic                       i_run,

   // ldq head
   input  logic                       i_ld_valid,
   input  logic [ADDR_W-1:0]          i_ld_addr,
   input  logic [lsu_pkg::TAG_W-1:0]  i_ld_tag,

   // stq head
   input  logic                       i_st_valid,
   input  logic [ADDR_W-1:0]          i_st_addr,
   input  logic [lsu_pkg::DATA_W-1:0] i_st_data,
   input  logic [lsu_pkg::BE_W-1:0]   i_st_be,

   output logic                       o_ld_pop,
   output logic                       o_st_pop,

   // ex0 op for the pipe
   output lsu_pkg::lsu_op_e           o_ex0_op,
   output logic [ADDR_W-1:0]          o_ex0_addr,
   output logic [lsu_pkg::DATA_W-1:0] o_ex0_data,
   output logic [lsu_pkg::BE_W-1:0]   o_ex0_be,
   output logic [lsu_pkg::TAG_W-1:0]  o_ex0_tag
);

   import lsu_pkg::*;

   logic w_ld_conflict;
   logic w_st_pick;
   logic w_ld_pick;

   // both heads valid, load loses and waits
   assign w_ld_conflict = i_ld_valid & i_st_valid;

   // store side always wins
   assign w_st_pick = i_run & i_st_valid;
   assign w_ld_pick = i_run & i_ld_valid & ~w_ld_conflict;

   assign o_st_pop = w_st_pick;
   assign o_ld_pop = w_ld_pick;

   // opcode for ex0, bubble when nothing picked
   always_comb begin
      if (w_st_pick) begin
         o_ex0_op = OP_STORE;
      end else if (w_ld_pick) begin
         o_ex0_op = OP_LOAD;
      end else begin
         o_ex0_op = OP_NONE;
      end
   end

   // address from the winner
   assign o_ex0_addr = w_st_pick ? i_st_addr : i_ld_addr;
   // store payload only
   assign o_ex0_data = w_st_pick ? i_st_data : '0;
   assign o_ex0_be   = w_st_pick ? i_st_be   : '0;
   // tag only means something on loads
   assign o_ex0_tag  = i_ld_tag;

endmodule : lsu_replay_arb

// ==== pipe/lsu_data_ram.sv ====
`timescale 1ns/100ps

module lsu_data_ram #(
   parameter int ADDR_W = 6
) (
   input  logic                       i_clk,
   input  logic                       i_we,
   // one enable per byte lane
   input  logic [lsu_pkg::BE_W-1:0]   i_be,
   input  logic [ADDR_W-1:0]          i_addr,
   input  logic [lsu_pkg::DATA_W-1:0] i_wdata,
   output logic [lsu_pkg::DATA_W-1:0] o_rdata
);

   import lsu_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] r_mem [DEPTH];
   logic [DATA_W-1:0] r_rdata;

   // ====================
   // byte-lane write
   // ====================

   always_ff @(posedge i_clk) begin
      if (i_we) begin
         for (int b = 0; b < BE_W; b++) begin
            if (i_be[b]) begin
               r_mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
            end
         end
      end
   end

   // registered read, old data on a same-cycle write
   always_ff @(posedge i_clk) begin
      r_rdata <= r_mem[i_addr];
   end

   assign o_rdata = r_rdata;

endmodule : lsu_data_ram

// ==== pipe/lsu_pipe.sv ====
`timescale 1ns/100ps

module lsu_pipe #(
   parameter int ADDR_W = 6
) (
   input  logic                       i_clk,
   input  logic                       i_rst,

   // clear sweep port
   input  logic                       i_clear_en,
   input  logic [ADDR_W-1:0]          i_clear_addr,

   // picked op from ex0
   input  lsu_pkg::lsu_op_e           i_ex0_op,
   input  logic [ADDR_W-1:0]          i_ex0_addr,
   input  logic [lsu_pkg::DATA_W-1:0] i_ex0_data,
   input  logic [lsu_pkg::BE_W-1:0]   i_ex0_be,
   input  logic [lsu_pkg::TAG_W-1:0]  i_ex0_tag,

   // store done in ex1
   output logic                       o_st_credit,

   // load result in ex2
   output logic                       o_wb_valid,
   output logic [lsu_pkg::TAG_W-1:0]  o_wb_tag,
   output logic [lsu_pkg::DATA_W-1:0] o_wb_data
);

   import lsu_pkg::*;

   // ex1 stage
   lsu_op_e           r_ex1_op;
   logic [ADDR_W-1:0] r_ex1_addr;
   logic [DATA_W-1:0] r_ex1_data;
   logic [BE_W-1:0]   r_ex1_be;
   logic [TAG_W-1:0]  r_ex1_tag;

   // ex2 stage
   logic              r_ex2_valid;
   logic [TAG_W-1:0]  r_ex2_tag;

   // ram port
   logic              w_ram_we;
   logic [BE_W-1:0]   w_ram_be;
   logic [ADDR_W-1:0] w_ram_addr;
   logic [DATA_W-1:0] w_ram_wdata;

   // ====================
   // ex0 -> ex1
   // ====================

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_ex1_op <= OP_NONE;
      end else begin
         r_ex1_op <= i_ex0_op;
      end
   end

   always_ff @(posedge i_clk) begin
      r_ex1_addr <= i_ex0_addr;
      r_ex1_data <= i_ex0_data;
      r_ex1_be   <= i_ex0_be;
      r_ex1_tag  <= i_ex0_tag;
   end

   // ram control, clear sweep owns the port while it runs
   assign w_ram_we    = i_clear_en | (r_ex1_op == OP_STORE);
   assign w_ram_be    = i_clear_en ? '1 : r_ex1_be;
   assign w_ram_addr  = i_clear_en ? i_clear_addr : r_ex1_addr;
   assign w_ram_wdata = i_clear_en ? '0 : r_ex1_data;

   // write lands at the end of ex1
   assign o_st_credit = (r_ex1_op == OP_STORE);

   lsu_data_ram #(
      .ADDR_W (ADDR_W)
   ) u_data_ram (
      .i_clk   (i_clk),
      .i_we    (w_ram_we),
      .i_be    (w_ram_be),
      .i_addr  (w_ram_addr),
      .i_wdata (w_ram_wdata),
      .o_rdata (o_wb_data)
   );

   // ====================
   // ex1 -> ex2
   // ====================

   // load tag rides along with the ram read
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_ex2_valid <= 1'b0;
      end else begin
         r_ex2_valid <= (r_ex1_op == OP_LOAD);
      end
   end

   always_ff @(posedge i_clk) begin
      r_ex2_tag <= r_ex1_tag;
   end

   assign o_wb_valid = r_ex2_valid;
   assign o_wb_tag   = r_ex2_tag;

endmodule : lsu_pipe

// ==== source/lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top #(
   parameter int ADDR_W      = 6,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                       i_clk,
   input  logic                       i_rst,

   // load requests, credit based
   input  logic                       i_ld_valid,
   input  logic [ADDR_W-1:0]          i_ld_addr,
   input  logic [lsu_pkg::TAG_W-1:0]  i_ld_tag,
   output logic                       o_ld_credit,

   // store requests, credit based
   input  logic                       i_st_valid,
   input  logic [ADDR_W-1:0]          i_st_addr,
   input  logic [lsu_pkg::DATA_W-1:0] i_st_data,
   input  logic [lsu_pkg::BE_W-1:0]   i_st_be,
   output logic                       o_st_credit,

   // load write-back, no stall
   output logic                       o_wb_valid,
   output logic [lsu_pkg::TAG_W-1:0]  o_wb_tag,
   output logic [lsu_pkg::DATA_W-1:0] o_wb_data,

   output logic                       o_init_done
);

   import lsu_pkg::*;

   // ldq head
   logic              w_ld_head_valid;
   logic [ADDR_W-1:0] w_ld_head_addr;
   logic [TAG_W-1:0]  w_ld_head_tag;

   // stq head
   logic              w_st_head_valid;
   logic [ADDR_W-1:0] w_st_head_addr;
   logic [DATA_W-1:0] w_st_head_data;
   logic [BE_W-1:0]   w_st_head_be;
   logic              w_st_pop;

   // picked op in ex0
   lsu_op_e           w_ex0_op;
   logic [ADDR_W-1:0] w_ex0_addr;
   logic [DATA_W-1:0] w_ex0_data;
   logic [BE_W-1:0]   w_ex0_be;
   logic [TAG_W-1:0]  w_ex0_tag;

   // ram clear sweep
   logic              w_clear_en;
   logic [ADDR_W-1:0] w_clear_addr;
   logic              w_clear_last;

   // ====================
   // replay buffers
   // ====================

   // load queue, data and be lanes unused
   lsu_replay_buf #(
      .ADDR_W      (ADDR_W),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_ldq_buf (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_push       (i_ld_valid),
      .i_push_addr  (i_ld_addr),
      .i_push_data  ('0),
      .i_push_be    ('0),
      .i_push_tag   (i_ld_tag),
      .i_pop        (o_ld_credit),
      .o_head_valid (w_ld_head_valid),
      .o_head_addr  (w_ld_head_addr),
      .o_head_data  (),
      .o_head_be    (),
      .o_head_tag   (w_ld_head_tag)
   );

   // store queue, no tag
   lsu_replay_buf #(
      .ADDR_W      (ADDR_W),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_stq_buf (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_push       (i_st_valid),
      .i_push_addr  (i_st_addr),
      .i_push_data  (i_st_data),
      .i_push_be    (i_st_be),
      .i_push_tag   ('0),
      .i_pop        (w_st_pop),
      .o_head_valid (w_st_head_valid),
      .o_head_addr  (w_st_head_addr),
      .o_head_data  (w_st_head_data),
      .o_head_be    (w_st_head_be),
      .o_head_tag   ()
   );

   // ex0 pick, ld pop doubles as ld credit
   lsu_replay_arb #(
      .ADDR_W (ADDR_W)
   ) u_replay_arb (
      .i_run      (o_init_done),
      .i_ld_valid (w_ld_head_valid),
      .i_ld_addr  (w_ld_head_addr),
      .i_ld_tag   (w_ld_head_tag),
      .i_st_valid (w_st_head_valid),
      .i_st_addr  (w_st_head_addr),
      .i_st_data  (w_st_head_data),
      .i_st_be    (w_st_head_be),
      .o_ld_pop   (o_ld_credit),
      .o_st_pop   (w_st_pop),
      .o_ex0_op   (w_ex0_op),
      .o_ex0_addr (w_ex0_addr),
      .o_ex0_data (w_ex0_data),
      .o_ex0_be   (w_ex0_be),
      .o_ex0_tag  (w_ex0_tag)
   );

   // ====================
   // init and pipeline
   // ====================

   lsu_init_fsm u_init_fsm (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_last     (w_clear_last),
      .o_clear_en (w_clear_en),
      .o_run      (o_init_done)
   );

   lsu_init_ctr #(
      .ADDR_W (ADDR_W)
   ) u_init_ctr (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_en   (w_clear_en),
      .o_addr (w_clear_addr),
      .o_last (w_clear_last)
   );

   lsu_pipe #(
      .ADDR_W (ADDR_W)
   ) u_lsu_pipe (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_clear_en   (w_clear_en),
      .i_clear_addr (w_clear_addr),
      .i_ex0_op     (w_ex0_op),
      .i_ex0_addr   (w_ex0_addr),
      .i_ex0_data   (w_ex0_data),
      .i_ex0_be     (w_ex0_be),
      .i_ex0_tag    (w_ex0_tag),
      .o_st_credit  (o_st_credit),
      .o_wb_valid   (o_wb_valid),
      .o_wb_tag     (o_wb_tag),
      .o_wb_data    (o_wb_data)
   );

endmodule : lsu_top

// ==== tb/lsu_checker.sv ====
`timescale 1ns/100ps

module lsu_checker #(
   parameter int ADDR_W      = 6,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                       i_clk,
   input  logic                       i_rst,
   // requests as the DUT sees them
   input  logic                       i_ld_valid,
   input  logic [ADDR_W-1:0]          i_ld_addr,
   input  logic [lsu_pkg::TAG_W-1:0]  i_ld_tag,
   input  logic                       i_st_valid,
   input  logic [ADDR_W-1:0]          i_st_addr,
   input  logic [lsu_pkg::DATA_W-1:0] i_st_data,
   input  logic [lsu_pkg::BE_W-1:0]   i_st_be,
   // DUT responses
   input  logic                       i_ld_credit,
   input  logic                       i_st_credit,
   input  logic                       i_wb_valid,
   input  logic [lsu_pkg::TAG_W-1:0]  i_wb_tag,
   input  logic [lsu_pkg::DATA_W-1:0] i_wb_data,
   input  logic                       i_init_done
);

   import lsu_pkg::*;

   // reference memory, zero after the clear sweep
   logic [DATA_W-1:0] mem_model [1 << ADDR_W];
   // expected results in issue order
   logic [TAG_W-1:0]  exp_tag_q  [$];
   logic [DATA_W-1:0] exp_data_q [$];
   logic [TAG_W-1:0]  exp_tag;
   logic [DATA_W-1:0] exp_data;

   int wb_errors;
   int credit_errors;
   int ctrl_errors;
   int ld_accepted;
   int st_accepted;
   int ld_credit_seen;
   int st_credit_seen;
   // sent but not yet credited back, per side
   int ld_out;
   int st_out;
   int clear_cycles;
   bit init_seen;

   initial begin
      for (int i = 0; i < (1 << ADDR_W); i++) begin
         mem_model[i] = '0;
      end
      wb_errors      = 0;
      credit_errors  = 0;
      ctrl_errors    = 0;
      ld_accepted    = 0;
      st_accepted    = 0;
      ld_credit_seen = 0;
      st_credit_seen = 0;
      ld_out         = 0;
      st_out         = 0;
      clear_cycles   = 0;
      init_seen      = 1'b0;
   end

   // ====================
   // init and quiet window
   // ====================

   // values sampled here are the ones from before the edge
   always @(posedge i_clk) begin
      if (i_rst === 1'b1) begin
         clear_cycles = 0;
         init_seen    = 1'b0;
      end else if (!init_seen) begin
         if (i_init_done === 1'b1) begin
            init_seen = 1'b1;
            if (clear_cycles != (1 << ADDR_W)) begin
               $display("CHECK FAILED time=%0t o_init_done rise cycle: expected %0d actual %0d",
                        $time, 1 << ADDR_W, clear_cycles);
               ctrl_errors++;
            end
         end else begin
            clear_cycles++;
         end
      end
      // nothing may move while reset or the sweep holds the unit
      if (i_rst === 1'b1 || i_init_done !== 1'b1) begin
         if (i_wb_valid === 1'b1 || i_ld_credit === 1'b1 || i_st_credit === 1'b1) begin
            $display("time=%0t a write-back or credit pulse showed up during reset or clearing",
                     $time);
            ctrl_errors++;
         end
      end
   end

   // ====================
   // model and compare
   // ====================

   always @(posedge i_clk) begin
      // store lands in the model at enqueue, byte lanes only
      if (i_st_valid === 1'b1) begin
         st_accepted++;
         st_out++;
         for (int b = 0; b < BE_W; b++) begin
            if (i_st_be[b]) begin
               mem_model[i_st_addr][b*8 +: 8] = i_st_data[b*8 +: 8];
            end
         end
      end
      // no store to this word is in flight, so the model is final
      if (i_ld_valid === 1'b1) begin
         ld_accepted++;
         ld_out++;
         exp_tag_q.push_back(i_ld_tag);
         exp_data_q.push_back(mem_model[i_ld_addr]);
      end
      if (i_ld_credit === 1'b1) begin
         ld_credit_seen++;
         ld_out--;
      end
      if (i_st_credit === 1'b1) begin
         st_credit_seen++;
         st_out--;
      end
      if (ld_out < 0 || st_out < 0) begin
         $display("time=%0t a credit came back with no request outstanding", $time);
         credit_errors++;
      end
      if (ld_out > QUEUE_DEPTH || st_out > QUEUE_DEPTH) begin
         $display("time=%0t a sender went past its %0d credits", $time, QUEUE_DEPTH);
         credit_errors++;
      end
      if (i_wb_valid === 1'b1) begin
         if (exp_tag_q.size() == 0) begin
            $display("time=%0t write-back seen with no load outstanding", $time);
            wb_errors++;
         end else begin
            exp_tag  = exp_tag_q.pop_front();
            exp_data = exp_data_q.pop_front();
            if (i_wb_tag !== exp_tag) begin
               $display("CHECK FAILED time=%0t o_wb_tag expected %h actual %h",
                        $time, exp_tag, i_wb_tag);
               wb_errors++;
            end
            if (i_wb_data !== exp_data) begin
               $display("CHECK FAILED time=%0t o_wb_data expected %h actual %h",
                        $time, exp_data, i_wb_data);
               wb_errors++;
            end
         end
      end
   end

   // ====================
   // end of run
   // ====================

   task automatic finish_checks(input int tb_errors, output int total);
      if (exp_tag_q.size() != 0) begin
         $display("%0d loads never returned a result", exp_tag_q.size());
         wb_errors++;
      end
      if (ld_credit_seen != ld_accepted) begin
         $display("CHECK FAILED time=%0t o_ld_credit pulses expected %0d actual %0d",
                  $time, ld_accepted, ld_credit_seen);
         credit_errors++;
      end
      if (st_credit_seen != st_accepted) begin
         $display("CHECK FAILED time=%0t o_st_credit pulses expected %0d actual %0d",
                  $time, st_accepted, st_credit_seen);
         credit_errors++;
      end
      if (!init_seen) begin
         $display("o_init_done never came up after reset");
         ctrl_errors++;
      end
      total = wb_errors + credit_errors + ctrl_errors + tb_errors;
      $display("errors: writeback=%0d credit=%0d control=%0d stimulus=%0d (loads %0d, stores %0d)",
               wb_errors, credit_errors, ctrl_errors, tb_errors, ld_accepted, st_accepted);
   endtask

endmodule : lsu_checker

// ==== tb/tb_lsu.sv ====
`timescale 1ns/100ps

module tb_lsu;

   import lsu_pkg::*;

   localparam int ADDR_W      = 6;
   localparam int QUEUE_DEPTH = 4;
   localparam int CLK_PERIOD  = 8;
   localparam int RST_CYCLES  = 10;
   // operations per test section
   localparam int N_EMPTY     = 8;
   localparam int N_FULL      = 16;
   localparam int N_MIX       = 200;
   localparam int N_BURST     = 24;
   localparam int NUM_OPS     = N_EMPTY + 4 * N_FULL + 2 * N_MIX + 2 * N_BURST;
   // twice the expected length as margin
   localparam int WATCHDOG_NS = (RST_CYCLES + (1 << ADDR_W) + NUM_OPS * 8) * CLK_PERIOD * 2;

   logic              i_clk = 1'b0;
   logic              i_rst;
   logic              i_ld_valid;
   logic [ADDR_W-1:0] i_ld_addr;
   logic [TAG_W-1:0]  i_ld_tag;
   logic              i_st_valid;
   logic [ADDR_W-1:0] i_st_addr;
   logic [DATA_W-1:0] i_st_data;
   logic [BE_W-1:0]   i_st_be;
   logic              o_ld_credit;
   logic              o_st_credit;
   logic              o_wb_valid;
   logic [TAG_W-1:0]  o_wb_tag;
   logic [DATA_W-1:0] o_wb_data;
   logic              o_init_done;

   // sender side state
   int                ld_credits = QUEUE_DEPTH;
   int                st_credits = QUEUE_DEPTH;
   int                tb_errors  = 0;
   logic [TAG_W-1:0]  next_tag   = '0;
   // words with a load or a store in flight
   logic [ADDR_W-1:0] ld_q [$];
   logic [ADDR_W-1:0] st_q [$];

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   lsu_top #(
      .ADDR_W      (ADDR_W),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) i_dut (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ld_valid  (i_ld_valid),
      .i_ld_addr   (i_ld_addr),
      .i_ld_tag    (i_ld_tag),
      .o_ld_credit (o_ld_credit),
      .i_st_valid  (i_st_valid),
      .i_st_addr   (i_st_addr),
      .i_st_data   (i_st_data),
      .i_st_be     (i_st_be),
      .o_st_credit (o_st_credit),
      .o_wb_valid  (o_wb_valid),
      .o_wb_tag    (o_wb_tag),
      .o_wb_data   (o_wb_data),
      .o_init_done (o_init_done)
   );

   lsu_checker #(
      .ADDR_W      (ADDR_W),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_checker (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ld_valid  (i_ld_valid),
      .i_ld_addr   (i_ld_addr),
      .i_ld_tag    (i_ld_tag),
      .i_st_valid  (i_st_valid),
      .i_st_addr   (i_st_addr),
      .i_st_data   (i_st_data),
      .i_st_be     (i_st_be),
      .i_ld_credit (o_ld_credit),
      .i_st_credit (o_st_credit),
      .i_wb_valid  (o_wb_valid),
      .i_wb_tag    (o_wb_tag),
      .i_wb_data   (o_wb_data),
      .i_init_done (o_init_done)
   );

   // ====================
   // credit returns
   // ====================

   // stores retire on their credit and loads on write-back
   always @(posedge i_clk) begin
      if (o_ld_credit === 1'b1) begin
         ld_credits++;
      end
      if (o_st_credit === 1'b1) begin
         st_credits++;
         if (st_q.size() > 0) begin
            st_q.delete(0);
         end
      end
      if (o_wb_valid === 1'b1) begin
         if (ld_q.size() > 0) begin
            ld_q.delete(0);
         end else begin
            $display("time=%0t write-back arrived with no load in flight", $time);
            tb_errors++;
         end
      end
   end

   // ====================
   // stimulus helpers
   // ====================

   function automatic logic [ADDR_W-1:0] rand_addr();
      logic [31:0] r;
      r = $urandom();
      return r[ADDR_W-1:0];
   endfunction

   // partial leaves out both empty and full masks
   function automatic logic [BE_W-1:0] rand_be(input bit partial);
      logic [31:0] r;
      r = $urandom();
      while (r[BE_W-1:0] == '0 || (partial && r[BE_W-1:0] == '1)) begin
         r = $urandom();
      end
      return r[BE_W-1:0];
   endfunction

   function automatic bit store_pending(input logic [ADDR_W-1:0] addr);
      foreach (st_q[i]) begin
         if (st_q[i] == addr) return 1'b1;
      end
      return 1'b0;
   endfunction

   function automatic bit load_pending(input logic [ADDR_W-1:0] addr);
      foreach (ld_q[i]) begin
         if (ld_q[i] == addr) return 1'b1;
      end
      return 1'b0;
   endfunction

   // one cycle of requests from a falling edge
   // a side is sent only with a credit and no same-word hazard
   task automatic issue(input bit want_ld, input logic [ADDR_W-1:0] ld_addr,
                        input bit want_st, input logic [ADDR_W-1:0] st_addr,
                        input logic [DATA_W-1:0] st_data, input logic [BE_W-1:0] st_be,
                        output bit did_ld, output bit did_st);
      did_ld     = want_ld && (ld_credits > 0) && !store_pending(ld_addr);
      i_ld_valid = did_ld;
      i_ld_addr  = ld_addr;
      i_ld_tag   = next_tag;
      if (did_ld) begin
         ld_q.push_back(ld_addr);
         ld_credits--;
         next_tag++;
      end
      // the load above already sits in ld_q
      did_st     = want_st && (st_credits > 0) && !load_pending(st_addr);
      i_st_valid = did_st;
      i_st_addr  = st_addr;
      i_st_data  = st_data;
      i_st_be    = st_be;
      if (did_st) begin
         st_q.push_back(st_addr);
         st_credits--;
      end
      @(negedge i_clk);
   endtask

   task automatic load_until_taken(input logic [ADDR_W-1:0] addr);
      bit did_ld;
      bit did_st;
      did_ld = 1'b0;
      while (!did_ld) begin
         issue(1'b1, addr, 1'b0, '0, '0, '0, did_ld, did_st);
      end
   endtask

   task automatic store_until_taken(input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] data,
                                    input logic [BE_W-1:0] be);
      bit did_ld;
      bit did_st;
      did_st = 1'b0;
      while (!did_st) begin
         issue(1'b0, '0, 1'b1, addr, data, be, did_ld, did_st);
      end
   endtask

   // wait until every request has come back
   task automatic wait_drain();
      i_ld_valid = 1'b0;
      i_st_valid = 1'b0;
      while (ld_q.size() != 0 || st_q.size() != 0) begin
         @(negedge i_clk);
      end
      repeat (4) @(negedge i_clk);
   endtask

   // each side asks with the given odds in quarters
   task automatic mixed_traffic(input int cycles, input int ld_odds, input int st_odds);
      bit                want_ld;
      bit                want_st;
      logic [ADDR_W-1:0] ld_addr;
      logic [ADDR_W-1:0] st_addr;
      logic [DATA_W-1:0] data;
      logic [BE_W-1:0]   be;
      bit                did_ld;
      bit                did_st;
      for (int i = 0; i < cycles; i++) begin
         want_ld = ($urandom() % 4) < ld_odds;
         want_st = ($urandom() % 4) < st_odds;
         ld_addr = rand_addr();
         st_addr = rand_addr();
         data    = $urandom();
         be      = rand_be(1'b0);
         issue(want_ld, ld_addr, want_st, st_addr, data, be, did_ld, did_st);
      end
   endtask

   // ====================
   // test sequence
   // ====================

   initial begin
      logic [31:0]       seed_ret;
      logic [ADDR_W-1:0] used_addr [N_FULL];
      logic [DATA_W-1:0] data;
      int                total_errors;
      bit                did_ld;
      bit                did_st;

      seed_ret   = $urandom(32'h17a9);
      i_rst      = 1'b1;
      i_ld_valid = 1'b0;
      i_ld_addr  = '0;
      i_ld_tag   = '0;
      i_st_valid = 1'b0;
      i_st_addr  = '0;
      i_st_data  = '0;
      i_st_be    = '0;
      repeat (RST_CYCLES) @(negedge i_clk);
      i_rst = 1'b0;

      // requests sent during the sweep sit until o_init_done
      // zero data keeps every word at its cleared value
      issue(1'b1, rand_addr(), 1'b1, rand_addr(), '0, '1, did_ld, did_st);
      i_ld_valid = 1'b0;
      i_st_valid = 1'b0;
      while (o_init_done !== 1'b1) begin
         @(negedge i_clk);
      end

      // cleared words read back as zero
      for (int i = 0; i < N_EMPTY; i++) begin
         load_until_taken(rand_addr());
      end
      wait_drain();

      // full-word stores and their read back
      for (int i = 0; i < N_FULL; i++) begin
         used_addr[i] = rand_addr();
         data         = $urandom();
         store_until_taken(used_addr[i], data, '1);
      end
      wait_drain();
      for (int i = 0; i < N_FULL; i++) begin
         load_until_taken(used_addr[i]);
      end
      wait_drain();

      // partial byte lanes over the same words
      for (int i = 0; i < N_FULL; i++) begin
         data = $urandom();
         store_until_taken(used_addr[i], data, rand_be(1'b1));
      end
      wait_drain();
      for (int i = 0; i < N_FULL; i++) begin
         load_until_taken(used_addr[i]);
      end
      wait_drain();

      // both sides busy so stores win and loads wait
      mixed_traffic(N_MIX, 3, 3);
      wait_drain();

      // ask every cycle until credits run dry
      mixed_traffic(N_BURST, 4, 4);
      wait_drain();

      if (ld_credits != QUEUE_DEPTH) begin
         $display("load sender ended with %0d credits instead of %0d", ld_credits, QUEUE_DEPTH);
         tb_errors++;
      end
      if (st_credits != QUEUE_DEPTH) begin
         $display("store sender ended with %0d credits instead of %0d", st_credits, QUEUE_DEPTH);
         tb_errors++;
      end

      u_checker.finish_checks(tb_errors, total_errors);
      if (total_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
      $display("Some tests failed");
      $finish;
   end

endmodule : tb_lsu

// ==== all.f ====
common/lsu_pkg.sv
source/lsu_init_fsm.sv
source/lsu_init_ctr.sv
replay/lsu_replay_buf.sv
replay/lsu_replay_arb.sv
pipe/lsu_data_ram.sv
pipe/lsu_pipe.sv
source/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv
